// ==== Makefile ====
TOP = grom_cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f grom_cpu.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== grom_cpu.f ====
hdl/grom_pkg.sv
hdl/grom_alu.sv
hdl/grom_regfile.sv
hdl/grom_control.sv
hdl/grom_cpu.sv
verification/grom_cpu_assertions.sv
verification/grom_cpu_tb.sv

// ==== hdl/grom_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_alu (
	input  wire                  clk,
	input  wire                  reset,
	input  wire grom_pkg::alu_req_t req,
	output grom_pkg::byte_t      result,
	output grom_pkg::alu_flags_t flags
);

	logic [grom_pkg::data_w:0] calc;     // Bit 8 is carry or borrow
	logic [grom_pkg::data_w:0] carry_in;

	assign carry_in = {{grom_pkg::data_w{1'b0}}, flags.cf};

	always_comb
	begin
		case (req.op)
			grom_pkg::alu_add:
				calc = {1'b0, req.a} + {1'b0, req.b};
			grom_pkg::alu_sub,
			grom_pkg::alu_cmp:
				calc = {1'b0, req.a} - {1'b0, req.b};
			grom_pkg::alu_adc:
				calc = {1'b0, req.a} + {1'b0, req.b} + carry_in;
			grom_pkg::alu_sbc:
				calc = {1'b0, req.a} - {1'b0, req.b} - carry_in;
			grom_pkg::alu_and,
			grom_pkg::alu_tst:
				calc = {1'b0, req.a & req.b};
			grom_pkg::alu_or:
				calc = {1'b0, req.a | req.b};
			grom_pkg::alu_not:
				calc = {1'b0, ~req.b};
			grom_pkg::alu_xor:
				calc = {1'b0, req.a ^ req.b};
			grom_pkg::alu_inc:
				calc = {1'b0, req.b} + 1'b1;
			grom_pkg::alu_dec:
				calc = {1'b0, req.b} - 1'b1; // Wraps to carry set at zero
			default:
				calc = {1'b0, req.a};
		endcase
	end

	// Flags only move on a request, so ADC and SBC see the last carry
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
		end
		else if (req.valid)
		begin
			flags.cf <= calc[grom_pkg::data_w];
			flags.zf <= (calc[grom_pkg::data_w-1:0] == '0);
			flags.sf <= calc[grom_pkg::data_w-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			result <= calc[grom_pkg::data_w-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/grom_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_control (
	input  wire                      clk,
	input  wire                      reset,
	input  wire grom_pkg::byte_t     data_in,
	output grom_pkg::mem_req_t       mem,
	output logic                     hlt,
	output grom_pkg::alu_req_t       alu_req,
	input  wire grom_pkg::byte_t     alu_result,
	input  wire grom_pkg::alu_flags_t alu_flags,
	output grom_pkg::reg_write_t     reg_wr,
	output grom_pkg::reg_sel_t       sel_a,
	output grom_pkg::reg_sel_t       sel_b,
	input  wire grom_pkg::byte_t     data_a,
	input  wire grom_pkg::byte_t     data_b
);

	grom_pkg::addr_t      pc;
	grom_pkg::byte_t      ir;
	grom_pkg::byte_t      value;      // Second instruction byte
	grom_pkg::reg_sel_t   result_reg;
	grom_pkg::cpu_state_t state;
	grom_pkg::alu_op_t    ir_alu_op;
	grom_pkg::addr_t      rel_target;
	logic [3:0]           group;
	logic                 jump;

	assign group      = ir[7:4];
	assign ir_alu_op  = grom_pkg::alu_op_t'({ir[5:4] - 2'd1, ir[3:2]});
	assign rel_target = pc + {{(grom_pkg::addr_w - grom_pkg::data_w){value[7]}}, value};

	always_comb
	begin
		case (ir[2:0])
			3'b000:  jump = 1'b1;
			3'b001:  jump = alu_flags.cf;
			3'b010:  jump = !alu_flags.cf;
			3'b011:  jump = alu_flags.sf;
			3'b100:  jump = !alu_flags.sf;
			3'b101:  jump = alu_flags.zf;
			3'b110:  jump = !alu_flags.zf;
			default: jump = 1'b0;
		endcase
	end

	// ALU groups always take R0 as first operand
	always_comb
	begin
		sel_a = ir[3:2];
		if (group == grom_pkg::op_arith || group == grom_pkg::op_logic ||
			group == grom_pkg::op_unary)
		begin
			sel_a = '0;
		end
	end

	assign sel_b = ir[1:0];

	always_comb
	begin
		reg_wr = '0;
		case (state)
			grom_pkg::state_execute:
				if (group == grom_pkg::op_mov)
				begin
					reg_wr = '{en: 1'b1, sel: ir[3:2], data: data_b};
				end
			grom_pkg::state_execute_dbl:
				if (group == grom_pkg::op_imm && ir[3:2] == 2'b00)
				begin
					reg_wr = '{en: 1'b1, sel: ir[1:0], data: value}; // MOV Rr,V
				end
			grom_pkg::state_load_value:
				reg_wr = '{en: 1'b1, sel: result_reg, data: data_in};
			grom_pkg::state_alu_result:
				reg_wr = '{en: 1'b1, sel: result_reg, data: alu_result};
			default:
				reg_wr = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		alu_req.valid <= 1'b0; // One cycle pulse
		if (reset)
		begin
			state  <= grom_pkg::state_reset;
			pc     <= grom_pkg::reset_pc;
			hlt    <= 1'b0;
			mem.we <= 1'b0;
		end
		else
		begin
			case (state)
				grom_pkg::state_reset:
					state <= grom_pkg::state_fetch_prep;
				grom_pkg::state_fetch_prep:
				begin
					mem.addr <= pc;
					mem.we   <= 1'b0;
					state    <= grom_pkg::state_fetch_wait;
				end
				grom_pkg::state_fetch_wait:
					state <= hlt ? grom_pkg::state_fetch_prep : grom_pkg::state_fetch;
				grom_pkg::state_fetch:
				begin
					ir    <= data_in;
					pc    <= pc + 1'b1;
					state <= grom_pkg::state_execute;
				end
				grom_pkg::state_execute:
				begin
					state <= grom_pkg::state_fetch_prep;
					if (ir[7])
					begin
						mem.addr <= pc; // Operand byte
						pc       <= pc + 1'b1;
						state    <= grom_pkg::state_fetch_value_prep;
					end
					else
					begin
						case (group)
							grom_pkg::op_arith,
							grom_pkg::op_logic:
							begin
								alu_req    <= '{valid: 1'b1, op: ir_alu_op, a: data_a, b: data_b};
								result_reg <= '0;
								state      <= grom_pkg::state_alu_result_wait;
							end
							grom_pkg::op_unary:
							begin
								alu_req    <= '{valid: 1'b1, op: ir_alu_op, a: data_a, b: data_b};
								result_reg <= ir[1:0];
								if (!ir[3]) // CMP and TST only set flags
								begin
									state <= grom_pkg::state_alu_result_wait;
								end
							end
							grom_pkg::op_load:
							begin
								mem.addr   <= {{(grom_pkg::addr_w - grom_pkg::data_w){1'b0}}, data_b};
								result_reg <= ir[3:2];
								state      <= grom_pkg::state_load_value_wait;
							end
							grom_pkg::op_store:
							begin
								mem.addr     <= {{(grom_pkg::addr_w - grom_pkg::data_w){1'b0}}, data_a};
								mem.data_out <= data_b;
								mem.we       <= 1'b1;
							end
							grom_pkg::op_halt:
								if (ir == grom_pkg::halt_byte)
								begin
									hlt <= 1'b1;
								end
							default:
								state <= grom_pkg::state_fetch_prep;
						endcase
					end
				end
				grom_pkg::state_fetch_value_prep:
					state <= grom_pkg::state_fetch_value;
				grom_pkg::state_fetch_value:
				begin
					value <= data_in;
					state <= grom_pkg::state_execute_dbl;
				end
				grom_pkg::state_execute_dbl:
				begin
					state <= grom_pkg::state_fetch_prep;
					case (group)
						grom_pkg::op_jr:
							if (ir[3] && jump)
							begin
								pc <= rel_target;
							end
						grom_pkg::op_jump:
							pc <= {ir[3:0], value};
						grom_pkg::op_imm:
							if (ir[3:2] == 2'b01)
							begin
								mem.addr   <= {{(grom_pkg::addr_w - grom_pkg::data_w){1'b0}}, value};
								result_reg <= ir[1:0];
								state      <= grom_pkg::state_load_value_wait;
							end
							else if (ir[3:2] == 2'b10)
							begin
								mem.addr     <= {{(grom_pkg::addr_w - grom_pkg::data_w){1'b0}}, value};
								mem.data_out <= data_b;
								mem.we       <= 1'b1;
							end
						default:
							state <= grom_pkg::state_fetch_prep;
					endcase
				end
				grom_pkg::state_load_value_wait:
					state <= grom_pkg::state_load_value; // Memory read in flight
				grom_pkg::state_load_value:
					state <= grom_pkg::state_fetch_prep;
				grom_pkg::state_alu_result_wait:
					state <= grom_pkg::state_alu_result;
				grom_pkg::state_alu_result:
					state <= grom_pkg::state_fetch_prep;
				default:
					state <= grom_pkg::state_fetch_prep;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/grom_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_cpu (
	input  wire                  clk,
	input  wire                  reset,
	output grom_pkg::addr_t      addr,
	input  wire grom_pkg::byte_t data_in,
	output grom_pkg::byte_t      data_out,
	output logic                 we,
	output logic                 hlt
);

	grom_pkg::mem_req_t   mem;
	grom_pkg::alu_req_t   alu_req;
	grom_pkg::byte_t      alu_result;
	grom_pkg::alu_flags_t alu_flags;
	grom_pkg::reg_write_t reg_wr;
	grom_pkg::reg_sel_t   sel_a;
	grom_pkg::reg_sel_t   sel_b;
	grom_pkg::byte_t      data_a;
	grom_pkg::byte_t      data_b;

	assign addr     = mem.addr;
	assign data_out = mem.data_out;
	assign we       = mem.we;

	grom_control i_grom_control (
		.clk        (clk),
		.reset      (reset),
		.data_in    (data_in),
		.mem        (mem),
		.hlt        (hlt),
		.alu_req    (alu_req),
		.alu_result (alu_result),
		.alu_flags  (alu_flags),
		.reg_wr     (reg_wr),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.data_a     (data_a),
		.data_b     (data_b)
	);

	grom_alu i_grom_alu (
		.clk    (clk),
		.reset  (reset),
		.req    (alu_req),
		.result (alu_result),
		.flags  (alu_flags)
	);

	grom_regfile i_grom_regfile (
		.clk    (clk),
		.reset  (reset),
		.wr     (reg_wr),
		.sel_a  (sel_a),
		.sel_b  (sel_b),
		.data_a (data_a),
		.data_b (data_b)
	);

endmodule

`default_nettype wire

// ==== hdl/grom_pkg.sv ====
`default_nettype none

package grom_pkg;

	localparam int addr_w = 12;
	localparam int data_w = 8;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] byte_t;
	typedef logic [1:0] reg_sel_t;

	localparam addr_t reset_pc = 12'h000;

	// Encoding follows {group - 1, ir[3:2]} of the ALU opcode groups
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_adc = 4'd2,
		alu_sbc = 4'd3,
		alu_and = 4'd4,
		alu_or  = 4'd5,
		alu_not = 4'd6,
		alu_xor = 4'd7,
		alu_inc = 4'd8,
		alu_dec = 4'd9,
		alu_cmp = 4'd10,
		alu_tst = 4'd11
	} alu_op_t;

	typedef enum logic [3:0] {
		state_reset            = 4'd0,
		state_fetch_prep       = 4'd1,
		state_fetch_wait       = 4'd2,
		state_fetch            = 4'd3,
		state_execute          = 4'd4,
		state_fetch_value_prep = 4'd5,
		state_fetch_value      = 4'd6,
		state_execute_dbl      = 4'd7,
		state_load_value       = 4'd8,
		state_load_value_wait  = 4'd9,
		state_alu_result_wait  = 4'd10,
		state_alu_result       = 4'd11
	} cpu_state_t;

	// Upper nibble group codes
	localparam logic [3:0] op_mov   = 4'h0;
	localparam logic [3:0] op_arith = 4'h1;
	localparam logic [3:0] op_logic = 4'h2;
	localparam logic [3:0] op_unary = 4'h3;
	localparam logic [3:0] op_load  = 4'h5;
	localparam logic [3:0] op_store = 4'h6;
	localparam logic [3:0] op_halt  = 4'h7;
	localparam logic [3:0] op_jr    = 4'h8;
	localparam logic [3:0] op_jump  = 4'h9;
	localparam logic [3:0] op_imm   = 4'hf;

	localparam byte_t halt_byte = 8'h7f;

	typedef struct packed {
		logic    valid;
		alu_op_t op;
		byte_t   a;
		byte_t   b;
	} alu_req_t;

	typedef struct packed {
		logic cf;
		logic zf;
		logic sf;
	} alu_flags_t;

	typedef struct packed {
		addr_t addr;
		byte_t data_out;
		logic  we;
	} mem_req_t;

	typedef struct packed {
		logic     en;
		reg_sel_t sel;
		byte_t    data;
	} reg_write_t;

endpackage

`default_nettype wire

// ==== hdl/grom_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_regfile (
	input  wire                     clk,
	input  wire                     reset,
	input  wire grom_pkg::reg_write_t wr,
	input  wire grom_pkg::reg_sel_t sel_a,
	input  wire grom_pkg::reg_sel_t sel_b,
	output grom_pkg::byte_t         data_a,
	output grom_pkg::byte_t         data_b
);

	grom_pkg::byte_t regs [4]; // R0 to R3

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr.en)
		begin
			regs[wr.sel] <= wr.data;
		end
	end

	assign data_a = regs[sel_a];
	assign data_b = regs[sel_b];

endmodule

`default_nettype wire

// ==== verification/grom_cpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_cpu_assertions (
	input wire clk,
	input wire reset,
	input wire we,
	input wire hlt
);

	// One write strobe per STORE
	single_write: assert property (@(posedge clk) disable iff (reset) we |=> !we)
		else $error("we high on two consecutive cycles");

	hlt_low_after_reset: assert property (@(posedge clk) reset |=> !hlt)
		else $error("hlt high in the cycle after reset");

	hlt_holds: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
		else $error("hlt dropped without a reset");

endmodule

bind grom_cpu grom_cpu_assertions i_grom_cpu_assertions (
	.clk   (clk),
	.reset (reset),
	.we    (we),
	.hlt   (hlt)
);

`default_nettype wire

// ==== verification/grom_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_cpu_tb;

	localparam int cycle_limit = 2000; // Well above four times the longest program

	logic clk;
	logic reset;
	grom_pkg::addr_t addr;
	grom_pkg::byte_t data_in = '0;
	grom_pkg::byte_t data_out;
	logic we;
	logic hlt;
	logic load_we;
	grom_pkg::addr_t load_addr;
	grom_pkg::byte_t load_data;
	grom_pkg::byte_t mem [4096];
	grom_pkg::byte_t prog [$];
	grom_pkg::addr_t skipped [$];
	int errors = 0;
	int cycles = 0;

	grom_cpu i_grom_cpu (.clk(clk), .reset(reset), .addr(addr), .data_in(data_in),
		.data_out(data_out), .we(we), .hlt(hlt));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Synchronous memory where the loader port wins during reset
	always @(posedge clk)
	begin
		if (load_we)
			mem[load_addr] <= load_data;
		else if (we)
			mem[addr] <= data_out;
		data_in <= mem[addr];
	end

	always @(posedge clk)
	begin
		cycles <= reset ? 0 : cycles + 1;
		if (!reset && cycles >= cycle_limit)
		begin
			$display("Timeout: the program did not halt within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	function automatic grom_pkg::byte_t fill_byte(grom_pkg::addr_t a);
		return a[7:0] ^ {4'h0, a[11:8]} ^ 8'h3c;
	endfunction

	task automatic check_byte(string name, grom_pkg::byte_t got, grom_pkg::byte_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(string name, grom_pkg::addr_t got, grom_pkg::addr_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_hlt(logic exp);
		if (hlt !== exp)
		begin
			$display("Fail hlt: got %h expected %h", hlt, exp);
			errors++;
		end
	endtask

	task automatic poke(grom_pkg::addr_t a, grom_pkg::byte_t d);
		@(negedge clk);
		load_we = 1'b1;
		load_addr = a;
		load_data = d;
	endtask

	// Holds reset while the low 256 bytes get the fill and the program
	task automatic load_program();
		reset = 1'b1;
		for (int i = 0; i < 256; i++)
			poke(grom_pkg::addr_t'(i), fill_byte(grom_pkg::addr_t'(i)));
		foreach (prog[i])
			poke(grom_pkg::addr_t'(i), prog[i]);
	endtask

	task automatic release_reset();
		@(negedge clk);
		load_we = 1'b0;
		repeat (5) @(negedge clk);
		check_hlt(1'b0);
		reset = 1'b0;
	endtask

	task automatic run_to_halt();
		release_reset();
		while (hlt !== 1'b1)
			@(negedge clk);
	endtask

	task automatic reset_and_immediate();
		prog = '{8'hf8, 8'h80, 8'hf9, 8'h81, 8'hfa, 8'h82, 8'hfb, 8'h83, 8'hf2, 8'ha7,
			8'hfa, 8'h84, 8'h7f};
		load_program();
		run_to_halt();
		for (int i = 0; i < 4; i++)
			check_byte("reset register", mem[12'h080 + i], 8'h00);
		check_byte("mov imm", mem[12'h084], 8'ha7);
	endtask

	task automatic alu_operations();
		prog = '{8'hf1, 8'hc8, 8'hf0, 8'h5a, 8'h11, 8'hf8, 8'h90, 8'hf0, 8'h10, 8'h19,
			8'hf8, 8'h91, 8'hf0, 8'h30, 8'h15, 8'hf8, 8'h92, 8'hf0, 8'h50, 8'h1d,
			8'hf8, 8'h93, 8'hf0, 8'h5a, 8'h21, 8'hf8, 8'h94, 8'hf0, 8'h5a, 8'h25,
			8'hf8, 8'h95, 8'hf0, 8'h5a, 8'h2d, 8'hf8, 8'h96, 8'h29, 8'hf8, 8'h97,
			8'h31, 8'hf9, 8'h98, 8'h36, 8'hfa, 8'h99, 8'h7f};
		load_program();
		run_to_halt();
		check_byte("add", mem[12'h090], 8'h5a + 8'hc8);
		check_byte("adc", mem[12'h091], 8'h10 + 8'hc8 + 8'h01); // Carry left by ADD
		check_byte("sub", mem[12'h092], 8'h30 - 8'hc8);
		check_byte("sbc", mem[12'h093], 8'h50 - 8'hc8 - 8'h01); // Borrow left by SUB
		check_byte("and", mem[12'h094], 8'h5a & 8'hc8);
		check_byte("or", mem[12'h095], 8'h5a | 8'hc8);
		check_byte("xor", mem[12'h096], 8'h5a ^ 8'hc8);
		check_byte("not", mem[12'h097], ~8'hc8);
		check_byte("inc", mem[12'h098], 8'hc8 + 8'h01);
		check_byte("dec", mem[12'h099], 8'h00 - 8'h01);
	endtask

	task automatic jumps();
		prog = '{8'hf0, 8'h40, 8'hf1, 8'h40, 8'hf2, 8'ha5, 8'hf3, 8'h0f, 8'h39,
			8'h8d, 8'h02, 8'hfb, 8'ha0, 8'hfa, 8'ha1, 8'h8e, 8'h02, 8'hfa, 8'ha2,
			8'h8a, 8'h02, 8'hfb, 8'ha3, 8'h3a, 8'h89, 8'h02, 8'hfb, 8'ha4,
			8'h8b, 8'h02, 8'hfb, 8'ha5, 8'h8c, 8'h02, 8'hfa, 8'ha6, 8'h3f,
			8'h8d, 8'h02, 8'hfb, 8'ha7, 8'h88, 8'h02, 8'hfb, 8'ha8, 8'h8f, 8'h02,
			8'hfa, 8'ha9, 8'h90, 8'h37, 8'hfb, 8'haa, 8'hfb, 8'hab, 8'hf8, 8'hac,
			8'hf9, 8'had, 8'hfb, 8'hae, 8'h7f};
		skipped = '{12'h0a0, 12'h0a3, 12'h0a4, 12'h0a5, 12'h0a7, 12'h0a8, 12'h0aa, 12'h0ab};
		load_program();
		run_to_halt();
		foreach (skipped[i])
			check_byte("skipped store", mem[skipped[i]], fill_byte(skipped[i]));
		check_byte("jrz marker", mem[12'h0a1], 8'ha5);
		check_byte("jrnz marker", mem[12'h0a2], 8'ha5);
		check_byte("jrns marker", mem[12'h0a6], 8'ha5);
		check_byte("never marker", mem[12'h0a9], 8'ha5);
		check_byte("r0 after cmp", mem[12'h0ac], 8'h40);
		check_byte("r1 after cmp", mem[12'h0ad], 8'h40);
		check_byte("r3 after tst", mem[12'h0ae], 8'h0f);
	endtask

	task automatic loads_and_stores();
		prog = '{8'hf1, 8'hc0, 8'h51, 8'hf6, 8'hc1, 8'hf3, 8'hd0, 8'h6c, 8'hfa, 8'hd1, 8'h7f};
		load_program();
		poke(12'h0c0, 8'h6b);
		poke(12'h0c1, 8'h9e);
		run_to_halt();
		check_byte("load indirect", mem[12'h0d0], 8'h6b);
		check_byte("load absolute", mem[12'h0d1], 8'h9e);
	endtask

	task automatic halt_hold();
		prog = '{8'hf0, 8'h33, 8'hf8, 8'he0, 8'h7f};
		load_program();
		run_to_halt();
		check_byte("store before halt", mem[12'h0e0], 8'h33);
		@(negedge clk);
		repeat (50)
		begin
			@(negedge clk);
			check_hlt(1'b1);
			check_addr("addr", addr, 12'h005);
			if (we)
			begin
				$display("A memory write appeared after halt");
				errors++;
			end
		end
	endtask

	task automatic second_reset();
		prog = '{8'hf9, 8'hf0, 8'h31, 8'hf9, 8'hf1, 8'h7f};
		load_program();
		run_to_halt();
		@(negedge clk);
		reset = 1'b1;
		poke(12'h0f0, fill_byte(12'h0f0));
		poke(12'h0f1, fill_byte(12'h0f1));
		release_reset();
		repeat (2) @(negedge clk);
		check_addr("addr", addr, grom_pkg::reset_pc);
		while (hlt !== 1'b1)
			@(negedge clk);
		check_byte("r1 after reset", mem[12'h0f0], 8'h00);
		check_byte("r1 incremented", mem[12'h0f1], 8'h01);
	endtask

	initial
	begin
		reset = 1'b1;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		reset_and_immediate();
		alu_operations();
		jumps();
		loads_and_stores();
		halt_hold();
		second_reset();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
